//--- bench/clockGen.sv
`timescale 1ns/10ps

module clockGen (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  initial begin
    rstN = 1'b0;
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

//--- bench/sqrtChecker.sv
`timescale 1ns/10ps

module sqrtChecker (
  input  logic clk,
  input  logic rstN,
  input  logic inAck,
  input  sqrtPkg::sqrtReq_t inPkt,
  input  logic outReq,
  input  sqrtPkg::sqrtResp_t outPkt,
  input  logic testEnd,
  input  int testIdx,
  output int checks,
  output int errors,
  output int pending
);
  import sqrtPkg::*;

  sqrtResp_t expQ[$];  // expected responses in request order
  logic inAckPrev;
  logic outReqPrev;
  int checkCnt = 0;
  int errCnt = 0;
  int checkMark = 0;
  int errMark = 0;

  function automatic laneRes_t laneModel(logic isSqrt, logic [15:0] a, logic [15:0] b);
    laneRes_t r;
    int root;
    root = 0;
    if (isSqrt) begin
      while ((root + 1) * (root + 1) <= a) root++;  // largest root with root^2 <= a
      r.quotient = root;
      r.remainder = a - root * root;
      r.divZero = 1'b0;
    end else if (b == 0) begin
      r.quotient = 16'hffff;
      r.remainder = a;
      r.divZero = 1'b1;
    end else begin
      r.quotient = a / b;
      r.remainder = a % b;
      r.divZero = 1'b0;
    end
    return r;
  endfunction

  function automatic sqrtResp_t expectFor(sqrtReq_t p);
    sqrtResp_t e;
    logic isSqrt;
    logic pair;
    isSqrt = (p.op == opSqrt2) || (p.op == opSqrt1);
    pair = (p.op == opDiv2) || (p.op == opSqrt2);
    e.tag = p.tag;
    e.lo = laneModel(isSqrt, p.aLo, p.bLo);
    e.hi = pair ? laneModel(isSqrt, p.aHi, p.bHi) : '0;  // unused lane reads zero
    return e;
  endfunction

  function automatic string testName(int idx);
    case (idx)
      1: return "paired divide";
      2: return "paired square root";
      3: return "single ops";
      4: return "divide by zero";
      default: return "mixed ops under outAck delay";
    endcase
  endfunction

  task automatic checkField(string name, logic [15:0] expVal, logic [15:0] actVal);
    if (expVal !== actVal) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
      errCnt++;
    end
  endtask

  task automatic compareResp();
    sqrtResp_t e;
    if (expQ.size() == 0) begin
      $display("response with tag %0h at %0t arrived with no request outstanding",
               outPkt.tag, $time);
      errCnt++;
    end else begin
      e = expQ.pop_front();
      checkCnt++;
      checkField("outPkt.tag", e.tag, outPkt.tag);
      checkField("outPkt.lo.quotient", e.lo.quotient, outPkt.lo.quotient);
      checkField("outPkt.lo.remainder", e.lo.remainder, outPkt.lo.remainder);
      checkField("outPkt.lo.divZero", e.lo.divZero, outPkt.lo.divZero);
      checkField("outPkt.hi.quotient", e.hi.quotient, outPkt.hi.quotient);
      checkField("outPkt.hi.remainder", e.hi.remainder, outPkt.hi.remainder);
      checkField("outPkt.hi.divZero", e.hi.divZero, outPkt.hi.divZero);
    end
  endtask

  always @(posedge clk) begin
    if (!rstN) begin
      inAckPrev <= 1'b0;
      outReqPrev <= 1'b0;
    end else begin
      inAckPrev <= inAck;
      outReqPrev <= outReq;
      if (inAck && !inAckPrev) expQ.push_back(expectFor(inPkt));  // request accepted
      if (outReq && !outReqPrev) compareResp();
      if (testEnd) begin
        $display("test %0d, %s: %0d responses, %0d errors", testIdx, testName(testIdx),
                 checkCnt - checkMark, errCnt - errMark);
        checkMark = checkCnt;
        errMark = errCnt;
      end
    end
    checks <= checkCnt;
    errors <= errCnt;
    pending <= expQ.size();
  end

endmodule

//--- bench/sqrtUnitTb.sv
`timescale 1ns/10ps

module sqrtUnitTb;
  import sqrtPkg::*;

  localparam int numTests = 5;
  localparam int reqPerTest = 60;
  localparam int cycleLimit = numTests * reqPerTest * 40;

  logic clk;
  logic rstN;
  logic inReq;
  sqrtReq_t inPkt;
  logic inAck;
  logic outReq;
  sqrtResp_t outPkt;
  logic outAck;
  logic testEnd;
  int testIdx;
  int checks;
  int errors;
  int pending;
  int cycleCnt = 0;
  logic [31:0] stimLfsr = 32'h9369;
  logic [31:0] ackLfsr = 32'h9369;  // separate state for the ack delays

  clockGen clocks (.clk(clk), .rstN(rstN));

  sqrtUnit sqrtUnit_i (
    .clk(clk),
    .rstN(rstN),
    .inReq(inReq),
    .inPkt(inPkt),
    .inAck(inAck),
    .outReq(outReq),
    .outPkt(outPkt),
    .outAck(outAck)
  );

  sqrtChecker respCheck (
    .clk(clk),
    .rstN(rstN),
    .inAck(inAck),
    .inPkt(inPkt),
    .outReq(outReq),
    .outPkt(outPkt),
    .testEnd(testEnd),
    .testIdx(testIdx),
    .checks(checks),
    .errors(errors),
    .pending(pending)
  );

  bind sqrtUnit sqrtUnitProps props (
    .clk(clk),
    .rstN(rstN),
    .inAck(inAck),
    .outReq(outReq),
    .outAck(outAck),
    .outPkt(outPkt),
    .doneLo(doneLo),
    .doneHi(doneHi),
    .busyLo(busyLo),
    .busyHi(busyHi),
    .take(take),
    .stateLo(laneLo.state),
    .stateHi(laneHi.state)
  );

  // Galois LFSR step for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  task automatic takeBits(inout logic [31:0] state, input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      val = {val[30:0], state[0]};
      state = lfsrStep(state);
    end
  endtask

  task automatic makeReq(input int t, input int i, output sqrtReq_t p);
    logic [31:0] r;
    takeBits(stimLfsr, 16, r);
    p.aLo = r[15:0];
    takeBits(stimLfsr, 16, r);
    p.aHi = r[15:0];
    takeBits(stimLfsr, 20, r);
    p.bLo = r[15:0] >> r[19:16];  // spread of divisor sizes
    takeBits(stimLfsr, 20, r);
    p.bHi = r[15:0] >> r[19:16];
    p.tag = i[3:0];
    takeBits(stimLfsr, 2, r);
    case (t)
      0: begin
        p.op = opDiv2;
        if (p.bLo == 0) p.bLo = 16'd1;
        if (p.bHi == 0) p.bHi = 16'd1;
      end
      1: p.op = opSqrt2;
      2: p.op = r[0] ? opSqrt1 : opDiv1;
      3: begin
        p.op = r[0] ? opDiv1 : opDiv2;
        if (r[1]) begin
          p.bHi = '0;
          if (p.bLo == 0) p.bLo = 16'd1;
        end else begin
          p.bLo = '0;
          if (p.bHi == 0) p.bHi = 16'd1;
        end
      end
      default: p.op = sqrtOp_e'(r[1:0]);
    endcase
  endtask

  // four-phase master that starts right after a rising edge
  task automatic sendReq(input sqrtReq_t p);
    inPkt <= p;
    inReq <= 1'b1;
    @(posedge clk);
    while (!inAck) @(posedge clk);
    inReq <= 1'b0;
    @(posedge clk);
    while (inAck) @(posedge clk);
  endtask

  initial begin
    sqrtReq_t pkt;
    inReq = 1'b0;
    inPkt = '0;
    testEnd = 1'b0;
    testIdx = 0;
    @(posedge clk);
    while (!rstN) @(posedge clk);
    for (int t = 0; t < numTests; t++) begin
      for (int i = 0; i < reqPerTest; i++) begin
        makeReq(t, i, pkt);
        sendReq(pkt);
      end
      while (pending != 0) @(posedge clk);  // drain before the test line
      testIdx <= t + 1;
      testEnd <= 1'b1;
      @(posedge clk);
      testEnd <= 1'b0;
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    $display("%0d responses checked, %0d errors, %0d assertion failures, %0d unanswered",
             checks, errors, sqrtUnit_i.props.failCount, pending);
    if (errors == 0 && pending == 0 && checks == numTests * reqPerTest &&
        sqrtUnit_i.props.failCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // outAck responder with 0 to 7 cycles of delay
  initial begin
    logic [31:0] delay;
    outAck = 1'b0;
    forever begin
      @(posedge clk);
      if (outReq && !outAck) begin
        takeBits(ackLfsr, 3, delay);
        repeat (delay) @(posedge clk);
        outAck <= 1'b1;
      end else if (!outReq && outAck) begin
        outAck <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= cycleLimit) begin
      $display("run timed out after %0d cycles with %0d requests unanswered",
               cycleCnt, pending);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

//--- bench/sqrtUnit_properties.sv
`timescale 1ns/10ps

module sqrtUnitProps (
  input logic clk,
  input logic rstN,
  input logic inAck,
  input logic outReq,
  input logic outAck,
  input sqrtPkg::sqrtResp_t outPkt,
  input logic doneLo,
  input logic doneHi,
  input logic busyLo,
  input logic busyHi,
  input logic take,
  input sqrtPkg::laneState_e stateLo,
  input sqrtPkg::laneState_e stateHi
);
  import sqrtPkg::*;

  int failCount = 0;  // assertion failures so far

  // handshake outputs and lane done come out of reset low
  resetLow: assert property (@(posedge clk)
    !rstN |=> !inAck && !outReq && !doneLo && !doneHi)
    else begin
      $error("inAck, outReq or a done signal high after reset");
      failCount++;
    end

  pktStable: assert property (@(posedge clk) disable iff (!rstN)
    outReq |=> !outReq || $stable(outPkt))
    else begin
      $error("outPkt changed while outReq was high");
      failCount++;
    end

  reqHeld: assert property (@(posedge clk) disable iff (!rstN)
    outReq && !outAck |=> outReq)  // four-phase order
    else begin
      $error("outReq fell before outAck rose");
      failCount++;
    end

  // a taken lane returns to idle with done and busy low
  idleLo: assert property (@(posedge clk) disable iff (!rstN)
    doneLo && take |=> stateLo == laneIdle && !doneLo && !busyLo)
    else begin
      $error("low lane not idle with done and busy low after take");
      failCount++;
    end

  idleHi: assert property (@(posedge clk) disable iff (!rstN)
    doneHi && take |=> stateHi == laneIdle && !doneHi && !busyHi)
    else begin
      $error("high lane not idle with done and busy low after take");
      failCount++;
    end

endmodule

//--- common/sqrtPkg.sv
package sqrtPkg;

  // lane geometry
  localparam int laneW = 16;
  localparam int tagW = 4;

  // iterations per operation in one lane core
  localparam int divSteps = laneW;       // one quotient bit per cycle
  localparam int sqrtSteps = laneW / 2;  // two radicand bits per cycle
  localparam int cntW = $clog2(divSteps);

  // opcode as seen on the request packet
  typedef enum logic [1:0] {
    opDiv2  = 2'd0,  // divide, both lanes
    opSqrt2 = 2'd1,  // square root, both lanes
    opDiv1  = 2'd2,  // divide, low lane only
    opSqrt1 = 2'd3   // square root, low lane only
  } sqrtOp_e;

  // lane core FSM
  typedef enum logic [1:0] {
    laneIdle = 2'd0,
    laneRun  = 2'd1,
    laneDone = 2'd2
  } laneState_e;

  // request from the outside, held stable while inReq is high
  typedef struct packed {
    sqrtOp_e op;
    logic [tagW-1:0] tag;
    logic [laneW-1:0] aLo;  // dividend or radicand
    logic [laneW-1:0] bLo;  // divisor, unused for sqrt
    logic [laneW-1:0] aHi;
    logic [laneW-1:0] bHi;
  } sqrtReq_t;

  // command into one lane core
  typedef struct packed {
    logic isSqrt;
    logic [laneW-1:0] a;
    logic [laneW-1:0] b;
  } laneCmd_t;

  // result out of one lane core
  typedef struct packed {
    logic [laneW-1:0] quotient;   // root for sqrt, zero-extended
    logic [laneW-1:0] remainder;
    logic divZero;
  } laneRes_t;

  // issue side bookkeeping, follows the operation into packing
  typedef struct packed {
    logic [tagW-1:0] tag;
    logic pair;  // high lane was started
  } issueInfo_t;

  // response to the outside
  typedef struct packed {
    logic [tagW-1:0] tag;
    laneRes_t lo;
    laneRes_t hi;
  } sqrtResp_t;

endpackage

//--- filelist.f
common/sqrtPkg.sv
sqrtLane/sqrtLaneCore.sv
source/sqrtIssue.sv
source/sqrtResultPack.sv
source/sqrtUnit.sv
bench/clockGen.sv
bench/sqrtUnit_properties.sv
bench/sqrtChecker.sv
bench/sqrtUnitTb.sv

//--- source/sqrtIssue.sv
`timescale 1ns/10ps

module sqrtIssue (
  input  logic clk,
  input  logic rstN,
  // four-phase input side
  input  logic inReq,
  input  sqrtPkg::sqrtReq_t inPkt,
  output logic inAck,
  // lane and packing status
  input  logic busyLo,
  input  logic busyHi,
  input  logic infoReady,
  // lane start
  output logic startLo,
  output logic startHi,
  output sqrtPkg::laneCmd_t cmdLo,
  output sqrtPkg::laneCmd_t cmdHi,
  // bookkeeping to packing
  output logic infoValid,
  output sqrtPkg::issueInfo_t info
);
  import sqrtPkg::*;

  logic held;          // holding register occupied
  sqrtReq_t holdPkt;
  logic accept;
  logic go;
  logic isSqrt;
  logic pair;

  // new request seen and nowhere else to go but the holding register
  assign accept = inReq && !inAck && !held;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      inAck <= 1'b0;
      held <= 1'b0;
    end else begin
      if (accept) begin
        inAck <= 1'b1;
      end else if (inAck && !inReq) begin
        inAck <= 1'b0;  // return to zero
      end

      if (accept) begin
        held <= 1'b1;
      end else if (go) begin
        held <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      holdPkt <= inPkt;
    end
  end

  // opcode decode
  always_comb begin
    case (holdPkt.op)
      opDiv2: begin
        isSqrt = 1'b0;
        pair = 1'b1;
      end
      opSqrt2: begin
        isSqrt = 1'b1;
        pair = 1'b1;
      end
      opDiv1: begin
        isSqrt = 1'b0;
        pair = 1'b0;
      end
      opSqrt1: begin
        isSqrt = 1'b1;
        pair = 1'b0;
      end
      default: begin
        isSqrt = 1'b0;
        pair = 1'b0;
      end
    endcase
  end

  // both cores idle and packing has room for the bookkeeping
  assign go = held && !busyLo && !busyHi && infoReady;

  assign startLo = go;
  assign startHi = go && pair;  // high lane stays idle for single ops
  assign infoValid = go;

  assign cmdLo = '{isSqrt: isSqrt, a: holdPkt.aLo, b: holdPkt.bLo};
  assign cmdHi = '{isSqrt: isSqrt, a: holdPkt.aHi, b: holdPkt.bHi};
  assign info = '{tag: holdPkt.tag, pair: pair};

endmodule

//--- source/sqrtResultPack.sv
`timescale 1ns/10ps

module sqrtResultPack (
  input  logic clk,
  input  logic rstN,
  // bookkeeping from issue
  input  logic infoValid,
  input  sqrtPkg::issueInfo_t info,
  output logic infoReady,
  // lane results
  input  logic doneLo,
  input  logic doneHi,
  input  sqrtPkg::laneRes_t resLo,
  input  sqrtPkg::laneRes_t resHi,
  output logic take,
  // four-phase output side
  output logic outReq,
  output sqrtPkg::sqrtResp_t outPkt,
  input  logic outAck
);
  import sqrtPkg::*;

  // output handshake phases
  typedef enum logic [1:0] {
    outEmpty   = 2'd0,
    outHold    = 2'd1,  // outReq high, waiting for outAck
    outRelease = 2'd2   // waiting for outAck to return low
  } outState_e;

  outState_e outState;
  logic infoFull;
  issueInfo_t infoReg;
  logic lanesDone;

  assign infoReady = !infoFull;

  // high lane only matters for paired ops
  assign lanesDone = infoFull && doneLo && (doneHi || !infoReg.pair);
  assign take = lanesDone && (outState == outEmpty);
  assign outReq = outState == outHold;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      infoFull <= 1'b0;
      outState <= outEmpty;
    end else begin
      if (infoValid) begin
        infoFull <= 1'b1;
      end else if (take) begin
        infoFull <= 1'b0;
      end

      case (outState)
        outEmpty: begin
          if (take) begin
            outState <= outHold;
          end
        end
        outHold: begin
          if (outAck) begin
            outState <= outRelease;
          end
        end
        outRelease: begin
          if (!outAck) begin
            outState <= outEmpty;  // register free again
          end
        end
        default: begin
          outState <= outEmpty;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (infoValid) begin
      infoReg <= info;
    end
    if (take) begin
      outPkt.tag <= infoReg.tag;
      outPkt.lo <= resLo;
      outPkt.hi <= infoReg.pair ? resHi : '0;  // idle lane reads zero
    end
  end

endmodule

//--- source/sqrtUnit.sv
`timescale 1ns/10ps

module sqrtUnit (
  input  logic clk,
  input  logic rstN,
  input  logic inReq,
  input  sqrtPkg::sqrtReq_t inPkt,
  output logic inAck,
  output logic outReq,
  output sqrtPkg::sqrtResp_t outPkt,
  input  logic outAck
);
  import sqrtPkg::*;

  // issue to cores
  logic startLo;
  logic startHi;
  laneCmd_t cmdLo;
  laneCmd_t cmdHi;
  logic busyLo;
  logic busyHi;

  // issue to packing
  logic infoValid;
  logic infoReady;
  issueInfo_t info;

  // cores to packing
  logic doneLo;
  logic doneHi;
  laneRes_t resLo;
  laneRes_t resHi;
  logic take;  // shared by both lanes

  sqrtIssue issue (
    .clk(clk),
    .rstN(rstN),
    .inReq(inReq),
    .inPkt(inPkt),
    .inAck(inAck),
    .busyLo(busyLo),
    .busyHi(busyHi),
    .infoReady(infoReady),
    .startLo(startLo),
    .startHi(startHi),
    .cmdLo(cmdLo),
    .cmdHi(cmdHi),
    .infoValid(infoValid),
    .info(info)
  );

  sqrtLaneCore laneLo (
    .clk(clk),
    .rstN(rstN),
    .start(startLo),
    .cmd(cmdLo),
    .busy(busyLo),
    .done(doneLo),
    .res(resLo),
    .take(take)
  );

  // high lane, started for paired ops only
  sqrtLaneCore laneHi (
    .clk(clk),
    .rstN(rstN),
    .start(startHi),
    .cmd(cmdHi),
    .busy(busyHi),
    .done(doneHi),
    .res(resHi),
    .take(take)
  );

  sqrtResultPack pack (
    .clk(clk),
    .rstN(rstN),
    .infoValid(infoValid),
    .info(info),
    .infoReady(infoReady),
    .doneLo(doneLo),
    .doneHi(doneHi),
    .resLo(resLo),
    .resHi(resHi),
    .take(take),
    .outReq(outReq),
    .outPkt(outPkt),
    .outAck(outAck)
  );

endmodule

//--- sqrtLane/sqrtLaneCore.sv
`timescale 1ns/10ps

module sqrtLaneCore (
  input  logic clk,
  input  logic rstN,
  input  logic start,
  input  sqrtPkg::laneCmd_t cmd,
  output logic busy,
  output logic done,
  output sqrtPkg::laneRes_t res,
  input  logic take
);
  import sqrtPkg::*;

  laneState_e state;
  logic [cntW-1:0] stepCnt;  // iterations left after this one

  // datapath registers, shared by divide and sqrt
  logic isSqrtReg;
  logic divZeroReg;
  logic [laneW-1:0] remReg;    // partial remainder
  logic [laneW-1:0] shiftReg;  // dividend shifting into quotient, or radicand
  logic [laneW-1:0] auxReg;    // divisor, or root being built

  // divide step
  logic [laneW:0] divShift;
  logic [laneW:0] divDiff;
  logic divFits;

  // sqrt step
  logic [laneW:0] sqShift;
  logic [laneW:0] sqTrial;
  logic [laneW:0] sqDiff;
  logic sqFits;

  logic [laneW-1:0] remNext;
  logic [laneW-1:0] shiftNext;
  logic [laneW-1:0] auxNext;

  logic load;

  assign load = (state == laneIdle) && start;

  // FSM
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= laneIdle;
      stepCnt <= '0;
    end else begin
      case (state)
        laneIdle: begin
          if (start) begin
            state <= laneRun;
            stepCnt <= cmd.isSqrt ? cntW'(sqrtSteps - 1) : cntW'(divSteps - 1);
          end
        end
        laneRun: begin
          if (stepCnt == '0) begin
            state <= laneDone;
          end
          stepCnt <= stepCnt - 1'b1;
        end
        laneDone: begin
          if (take) begin
            state <= laneIdle;  // result consumed by packing
          end
        end
        default: begin
          state <= laneIdle;
        end
      endcase
    end
  end

  // one iteration of either algorithm
  always_comb begin
    // restoring division, bring down next dividend bit
    divShift = {remReg, shiftReg[laneW-1]};
    divFits = divShift >= {1'b0, auxReg};
    divDiff = divShift - {1'b0, auxReg};

    // digit-by-digit root, bring down next two radicand bits
    sqShift = {remReg[laneW-2:0], shiftReg[laneW-1 -: 2]};
    sqTrial = {auxReg[laneW-2:0], 2'b01};  // 4*root + 1
    sqFits = sqShift >= sqTrial;
    sqDiff = sqShift - sqTrial;

    if (isSqrtReg) begin
      remNext = sqFits ? sqDiff[laneW-1:0] : sqShift[laneW-1:0];
      shiftNext = {shiftReg[laneW-3:0], 2'b00};
      auxNext = {auxReg[laneW-2:0], sqFits};
    end else begin
      remNext = divFits ? divDiff[laneW-1:0] : divShift[laneW-1:0];
      shiftNext = {shiftReg[laneW-2:0], divFits};
      auxNext = auxReg;
    end
  end

  // with a zero divisor every step fits, which leaves an all-ones
  // quotient and the dividend in the remainder on the normal schedule
  always_ff @(posedge clk) begin
    if (load) begin
      isSqrtReg <= cmd.isSqrt;
      divZeroReg <= !cmd.isSqrt && (cmd.b == '0);
      remReg <= '0;
      shiftReg <= cmd.a;
      auxReg <= cmd.isSqrt ? '0 : cmd.b;
    end else if (state == laneRun) begin
      remReg <= remNext;
      shiftReg <= shiftNext;
      auxReg <= auxNext;
    end
  end

  assign busy = state != laneIdle;  // done counts as busy until taken
  assign done = state == laneDone;

  // root never exceeds 8 bits, so auxReg is already zero-extended
  assign res.quotient = isSqrtReg ? auxReg : shiftReg;
  assign res.remainder = remReg;
  assign res.divZero = divZeroReg;

endmodule
